/* verilog.f */
fp_pkg.sv
lzc24.sv
fp_add_sub_pipe.sv
fp_wb_regs.sv
fp_accel_top.sv
fp_accel_checker.sv
tb_fp_accel.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fp accelerator testbench with Verilator, then check the log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
   --top-module tb_fp_accel -f verilog.f -o sim_fp_accel > build.log 2>&1 \
   || { echo "compile failed, see build.log"; exit 1; }
./obj_dir/sim_fp_accel > sim.log 2>&1 \
   || { echo "simulation aborted, see sim.log"; exit 1; }
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

/* tb_fp_accel.sv */
`default_nettype none

module tb_fp_accel
   import fp_pkg::*;
();

   timeunit 1ns;
   timeprecision 10ps;

   localparam int N_RANDOM   = 200;
   // generous worst case per random op with room for the later tests
   localparam int OP_CYCLES  = 50;
   localparam int MAX_CYCLES = 2 * N_RANDOM * OP_CYCLES;

   logic    clk;
   logic    rst_n;
   logic    wb_cyc;
   logic    wb_stb;
   logic    wb_we;
   wb_adr_t wb_adr;
   wb_dat_t wb_dat_w;
   wb_dat_t wb_dat_r;
   logic    wb_ack;

   int          n_checks = 0;
   int          n_errors = 0;
   int          cycles   = 0;
   logic [31:0] seed;

   // expected {overflow, underflow, result} per launch in launch order
   logic [33:0] pending [$];

   // checks waiting for the compare process
   string       chk_name [$];
   logic [31:0] chk_exp  [$];
   logic [31:0] chk_act  [$];

   fp_accel_top UUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic compare_val(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      n_checks = n_checks + 1;
      if (actual !== expected) begin
         n_errors = n_errors + 1;
         $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   // compare away from the edges the stimulus uses
   always @(negedge clk) begin
      while (chk_act.size() > 0) begin
         compare_val(chk_name.pop_front(), chk_exp.pop_front(), chk_act.pop_front());
      end
   end

   task automatic push_check(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      chk_name.push_back(name);
      chk_exp.push_back(expected);
      chk_act.push_back(actual);
   endtask

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // exact sum on a fixed grid with lsb 2^-149 and then one rounding to 24 bits
   function automatic logic [33:0] fp_ref(input fp32_t a, input fp32_t b, input logic sub);
      logic         sa, sb, sr;
      exp_t         ea, eb;
      logic [279:0] va, vb, mag, rem, half;
      logic [24:0]  q;
      int           p, k, e;
      sa = a[31];
      sb = b[31] ^ sub;
      ea = a[30:23];
      eb = b[30:23];
      if (ea == 8'hff || eb == 8'hff) begin
         return {2'b00, (ea == 8'hff) ? sa : sb, 8'hff, 23'b0};
      end
      va = (ea == 8'h00) ? '0 : 280'({1'b1, a[22:0]}) << (ea - 1);
      vb = (eb == 8'h00) ? '0 : 280'({1'b1, b[22:0]}) << (eb - 1);
      if (sa == sb) begin
         mag = va + vb;
         sr  = sa;
      end else if (va >= vb) begin
         mag = va - vb;
         sr  = sa;
      end else begin
         mag = vb - va;
         sr  = sb;
      end
      if (mag == '0) begin
         return {2'b00, sa & sb, 31'b0};
      end
      p = 0;
      for (int i = 0; i < 280; i++) begin
         if (mag[i]) begin
            p = i;
         end
      end
      if (p <= 23) begin
         q = 25'(mag << (23 - p));
      end else begin
         k    = p - 23;
         q    = 25'(mag >> k);
         rem  = mag & ((280'd1 << k) - 280'd1);
         half = 280'd1 << (k - 1);
         if (rem > half || (rem == half && q[0])) begin
            q = q + 25'd1;
         end
      end
      e = p - 22;
      if (q[24]) begin
         q = q >> 1;
         e = e + 1;
      end
      if (e >= 255) begin
         return {2'b10, sr, 8'hff, 23'b0};
      end
      if (e < 1) begin
         return {2'b01, sr, 31'b0};
      end
      return {2'b00, sr, 8'(e), q[22:0]};
   endfunction

   // entered and left 2 ns after a rising edge
   task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                            output wb_dat_t rdat);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = dat;
      do begin
         @(posedge clk);
         #2;
      end while (!wb_ack);
      rdat = wb_dat_r;
      // hold until the edge that samples ack has passed
      @(posedge clk);
      #2;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
      wb_dat_t rd_ignored;
      bus_cycle(1'b1, adr, dat, rd_ignored);
   endtask

   task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
      bus_cycle(1'b0, adr, '0, dat);
   endtask

   task automatic launch(input fp32_t a, input fp32_t b, input logic sub);
      wb_write(ADR_OP_A, a);
      wb_write(ADR_OP_B, b);
      wb_write(ADR_CTRL, {31'b0, sub});
      pending.push_back(fp_ref(a, b, sub));
   endtask

   task automatic wait_queue(input logic [2:0] count, output wb_dat_t st);
      do begin
         wb_read(ADR_STATUS, st);
      end while (st[6:4] != count);
   endtask

   task automatic pop_result();
      wb_dat_t     res;
      logic [33:0] ref_v;
      wb_read(ADR_RESULT, res);
      ref_v = pending.pop_front();
      push_check("result", ref_v[31:0], res);
   endtask

   task automatic single_op(input fp32_t a, input fp32_t b, input logic sub);
      wb_dat_t st;
      launch(a, b, sub);
      wait_queue(3'd1, st);
      push_check("status overflow", 32'(pending[0][33]), 32'(st[0]));
      push_check("status underflow", 32'(pending[0][32]), 32'(st[1]));
      pop_result();
   endtask

   // model against a hand-worked value first and then the DUT against the model
   task automatic directed_op(input fp32_t a, input fp32_t b, input logic sub,
                              input fp32_t exp_res, input logic [1:0] exp_flags);
      logic [33:0] ref_v;
      ref_v = fp_ref(a, b, sub);
      push_check("fp_ref result", exp_res, ref_v[31:0]);
      push_check("fp_ref flags", 32'(exp_flags), 32'(ref_v[33:32]));
      single_op(a, b, sub);
   endtask

   task automatic rand_pair(output fp32_t a, output fp32_t b, output logic sub);
      logic [31:0] r1, r2, r3;
      int          ea, eb;
      seed = lcg(seed);
      r1   = seed;
      seed = lcg(seed);
      r2   = seed;
      seed = lcg(seed);
      r3   = seed;
      ea   = 1 + int'(r3[23:16]) % 254;
      if (r3[15]) begin
         eb = 1 + int'(r3[31:24]) % 254;
      end else begin
         // close exponents for cancellation and carries
         eb = ea + int'(r3[13:11]) - 3;
         eb = (eb < 1) ? 1 : (eb > 254) ? 254 : eb;
      end
      a   = {r1[31], 8'(ea), r1[30:8]};
      b   = {r2[31], 8'(eb), r2[30:8]};
      sub = r3[14];
   endtask

   task automatic finish_test(input string name, input int err_before);
      while (chk_act.size() != 0) begin
         @(posedge clk);
      end
      #2;
      $display("%s: finished with %0d errors", name, n_errors - err_before);
   endtask

   task automatic random_ops();
      int    err0;
      fp32_t a, b;
      logic  sub;
      err0 = n_errors;
      for (int i = 0; i < N_RANDOM; i++) begin
         rand_pair(a, b, sub);
         single_op(a, b, sub);
      end
      finish_test("random add and subtract", err0);
   endtask

   task automatic directed_cases();
      int err0;
      err0 = n_errors;
      directed_op(32'h3f800000, 32'h3f800000, 1'b1, 32'h00000000, 2'b00);
      directed_op(32'h40490fdb, 32'hc0490fdb, 1'b0, 32'h00000000, 2'b00);
      directed_op(32'h00000000, 32'h41200000, 1'b0, 32'h41200000, 2'b00);
      // ties rounding down and then up to the even neighbour
      directed_op(32'h3f800000, 32'h33800000, 1'b0, 32'h3f800000, 2'b00);
      directed_op(32'h3f800001, 32'h33800000, 1'b0, 32'h3f800002, 2'b00);
      // 23-place normalize
      directed_op(32'h3f800001, 32'h3f800000, 1'b1, 32'h34000000, 2'b00);
      finish_test("directed cases", err0);
   endtask

   task automatic range_limits();
      int err0;
      err0 = n_errors;
      directed_op(32'h7f7fffff, 32'h7f7fffff, 1'b0, 32'h7f800000, 2'b10);
      directed_op(32'h00800001, 32'h00800000, 1'b1, 32'h00000000, 2'b01);
      directed_op(32'h7f800000, 32'h7f800000, 1'b0, 32'h7f800000, 2'b00);
      directed_op(32'hff800000, 32'h7f800000, 1'b1, 32'hff800000, 2'b00);
      finish_test("range limits", err0);
   endtask

   task automatic pipelined_launches();
      int      err0;
      fp32_t   a, b;
      logic    sub;
      wb_dat_t st, v;
      err0 = n_errors;
      rand_pair(a, b, sub);
      wb_write(ADR_OP_A, a);
      wb_write(ADR_OP_B, b);
      // control writes two cycles apart keep several operations in flight
      for (int i = 0; i < 4; i++) begin
         wb_write(ADR_CTRL, {31'b0, sub});
         pending.push_back(fp_ref(a, b, sub));
         // alternate add and subtract so the pop order shows
         sub = !sub;
      end
      // launches 3 and 4 still inside the four-clock pipeline
      wb_read(ADR_CTRL, v);
      push_check("in-flight count", 32'd2, v);
      wait_queue(3'd4, st);
      for (int i = 0; i < 4; i++) begin
         pop_result();
      end
      wb_read(ADR_CTRL, v);
      push_check("in-flight count", 32'd0, v);
      finish_test("pipelining", err0);
   endtask

   task automatic backpressure_launches();
      int      err0;
      fp32_t   a, b;
      logic    sub;
      wb_dat_t st, v;
      err0 = n_errors;
      for (int i = 0; i < 4; i++) begin
         rand_pair(a, b, sub);
         launch(a, b, sub);
      end
      // fifth launch with no room left
      rand_pair(a, b, sub);
      wb_write(ADR_OP_A, a);
      wb_write(ADR_OP_B, b);
      wb_write(ADR_CTRL, {31'b0, sub});
      do begin
         wb_read(ADR_CTRL, v);
      end while (v != '0);
      wb_read(ADR_STATUS, st);
      push_check("status lost", 32'd1, 32'(st[2]));
      push_check("status count", 32'd4, 32'(st[6:4]));
      for (int i = 0; i < 4; i++) begin
         pop_result();
      end
      wb_read(ADR_STATUS, st);
      push_check("status lost", 32'd0, 32'(st[2]));
      push_check("status count", 32'd0, 32'(st[6:4]));
      finish_test("back-pressure", err0);
   endtask

   task automatic empty_reads();
      int      err0;
      wb_dat_t v;
      err0 = n_errors;
      wb_read(ADR_RESULT, v);
      push_check("empty result", 32'd0, v);
      // returning at all means address 7 was acknowledged
      wb_read(3'd7, v);
      push_check("unmapped read", 32'd0, v);
      finish_test("empty and unmapped reads", err0);
   endtask

   initial begin
      seed     = 32'hbcb3;
      rst_n    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      repeat (5) @(posedge clk);
      #2;
      rst_n = 1'b1;
      random_ops();
      directed_cases();
      range_limits();
      pipelined_launches();
      backpressure_launches();
      empty_reads();
      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* fp_accel_checker.sv */
`default_nettype none

module fp_accel_checker
   import fp_pkg::*;
(
   input logic clk,
   input logic rst_n,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack,
   input logic in_valid,
   input logic out_valid,
   input logic overflow,
   input logic underflow
);

   timeunit 1ns;
   timeprecision 10ps;

   // ack answers a live request, one cycle at a time
   ack_with_request: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |-> (wb_cyc && wb_stb))
      else $error("wb_ack high without cyc and stb");

   ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |=> !wb_ack)
      else $error("wb_ack high for two cycles in a row");

   // fixed latency, checked from both ends
   launch_to_result: assert property (@(posedge clk) disable iff (!rst_n)
      in_valid |-> ##PIPE_LAT out_valid)
      else $error("out_valid missing PIPE_LAT cycles after in_valid");

   result_from_launch: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> $past(in_valid, PIPE_LAT))
      else $error("out_valid without a matching in_valid");

   flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> !(overflow && underflow))
      else $error("overflow and underflow both high");

endmodule

bind fp_accel_top fp_accel_checker u_checker (
   .clk       (clk),
   .rst_n     (rst_n),
   .wb_cyc    (wb_cyc),
   .wb_stb    (wb_stb),
   .wb_ack    (wb_ack),
   .in_valid  (in_valid),
   .out_valid (out_valid),
   .overflow  (overflow),
   .underflow (underflow)
);

`default_nettype wire

/* fp_accel_top.sv */
`default_nettype none

module fp_accel_top
   import fp_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    wb_cyc,
   input  logic    wb_stb,
   input  logic    wb_we,
   input  wb_adr_t wb_adr,
   input  wb_dat_t wb_dat_w,
   output wb_dat_t wb_dat_r,
   output logic    wb_ack
);

   logic  in_valid, sel, out_valid, overflow, underflow;
   fp32_t a_in, b_in, result;

   // bus side, operands and result queue
   fp_wb_regs u_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .in_valid  (in_valid),
      .a_in      (a_in),
      .b_in      (b_in),
      .sel       (sel),
      .out_valid (out_valid),
      .result    (result),
      .overflow  (overflow),
      .underflow (underflow)
   );

   fp_add_sub_pipe u_pipe (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .a_in      (a_in),
      .b_in      (b_in),
      .sel       (sel),
      .out_valid (out_valid),
      .result    (result),
      .overflow  (overflow),
      .underflow (underflow)
   );

endmodule

`default_nettype wire

/* fp_wb_regs.sv */
`default_nettype none

module fp_wb_regs
   import fp_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    wb_cyc,
   input  logic    wb_stb,
   input  logic    wb_we,
   input  wb_adr_t wb_adr,
   input  wb_dat_t wb_dat_w,
   output wb_dat_t wb_dat_r,
   output logic    wb_ack,
   output logic    in_valid,
   output fp32_t   a_in,
   output fp32_t   b_in,
   output logic    sel,
   input  logic    out_valid,
   input  fp32_t   result,
   input  logic    overflow,
   input  logic    underflow
);

   logic             req, wr, rd;
   logic             ctrl_wr, room, launch;
   logic             push, pop, q_empty;
   logic [CNT_W-1:0] q_count, in_flight;
   logic [PTR_W-1:0] wr_ptr, rd_ptr;
   logic             lost;
   fp32_t            q_res [RES_DEPTH];
   logic [RES_DEPTH-1:0] q_ovf, q_unf;
   wb_dat_t          rd_data;

   // a request is new while ack is still low
   assign req = wb_cyc && wb_stb && !wb_ack;
   assign wr  = req && wb_we;
   assign rd  = req && !wb_we;

   // refuse a launch that could find the queue full on arrival
   assign ctrl_wr = wr && (wb_adr == ADR_CTRL);
   assign room    = (q_count + in_flight) < CNT_W'(RES_DEPTH);
   assign launch  = ctrl_wr && room;

   assign q_empty = (q_count == '0);
   assign push    = out_valid;
   assign pop     = rd && (wb_adr == ADR_RESULT) && !q_empty;

   always_comb begin
      case (wb_adr)
         ADR_OP_A:   rd_data = a_in;
         ADR_OP_B:   rd_data = b_in;
         ADR_CTRL:   rd_data = wb_dat_t'(in_flight);
         ADR_RESULT: rd_data = q_empty ? '0 : q_res[rd_ptr];
         ADR_STATUS: rd_data = {25'b0, q_count, 1'b0, lost,
                                q_unf[rd_ptr] & !q_empty,
                                q_ovf[rd_ptr] & !q_empty};
         default:    rd_data = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_ack    <= 1'b0;
         wb_dat_r  <= '0;
         in_valid  <= 1'b0;
         in_flight <= '0;
         q_count   <= '0;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         lost      <= 1'b0;
      end else begin
         wb_ack    <= req;
         if (rd) begin
            wb_dat_r <= rd_data;
         end
         in_valid  <= launch;
         in_flight <= in_flight + CNT_W'(launch) - CNT_W'(out_valid);
         q_count   <= q_count + CNT_W'(push) - CNT_W'(pop);
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // sticky until the host reads status
         if (ctrl_wr && !room) begin
            lost <= 1'b1;
         end else if (rd && (wb_adr == ADR_STATUS)) begin
            lost <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr && (wb_adr == ADR_OP_A)) begin
         a_in <= wb_dat_w;
      end
      if (wr && (wb_adr == ADR_OP_B)) begin
         b_in <= wb_dat_w;
      end
      if (launch) begin
         sel <= wb_dat_w[0];
      end
      if (push) begin
         q_res[wr_ptr] <= result;
         q_ovf[wr_ptr] <= overflow;
         q_unf[wr_ptr] <= underflow;
      end
   end

endmodule

`default_nettype wire

/* fp_add_sub_pipe.sv */
`default_nettype none

module fp_add_sub_pipe
   import fp_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  in_valid,
   input  fp32_t a_in,
   input  fp32_t b_in,
   input  logic  sel,
   output logic  out_valid,
   output fp32_t result,
   output logic  overflow,
   output logic  underflow
);

   // one valid bit per register bank
   logic [PIPE_LAT-1:0] vld_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[PIPE_LAT-2:0], in_valid};
      end
   end

   assign out_valid = vld_q[PIPE_LAT-1];

   // stage 1: unpack, subnormals flushed to zero
   exp_t s1_exp_a, s1_exp_b;
   man_t s1_man_a, s1_man_b;
   logic s1_sign_b;

   assign s1_exp_a  = a_in[30:23];
   assign s1_exp_b  = b_in[30:23];
   assign s1_man_a  = (s1_exp_a == '0) ? '0 : {1'b1, a_in[22:0]};
   assign s1_man_b  = (s1_exp_b == '0) ? '0 : {1'b1, b_in[22:0]};
   // subtract flips the sign of b
   assign s1_sign_b = b_in[31] ^ sel;

   logic s2_sign_a, s2_sign_b;
   exp_t s2_exp_a, s2_exp_b;
   man_t s2_man_a, s2_man_b;

   always_ff @(posedge clk) begin
      s2_sign_a <= a_in[31];
      s2_sign_b <= s1_sign_b;
      s2_exp_a  <= s1_exp_a;
      s2_exp_b  <= s1_exp_b;
      s2_man_a  <= s1_man_a;
      s2_man_b  <= s1_man_b;
   end

   // stage 2: order by magnitude, align the smaller one
   logic        a_big;
   exp_t        exp_diff;
   man_t        man_big, man_small;
   logic [49:0] small_wide;
   logic [26:0] small_al;
   logic        inf_a, inf_b;

   assign a_big     = (s2_exp_a > s2_exp_b) ||
                      ((s2_exp_a == s2_exp_b) && (s2_man_a >= s2_man_b));
   assign exp_diff  = a_big ? (s2_exp_a - s2_exp_b) : (s2_exp_b - s2_exp_a);
   assign man_big   = a_big ? s2_man_a : s2_man_b;
   assign man_small = a_big ? s2_man_b : s2_man_a;
   assign inf_a     = (s2_exp_a == EXP_MAX);
   assign inf_b     = (s2_exp_b == EXP_MAX);

   // 24 mantissa bits, guard, round, then sticky as the lsb
   assign small_wide = {man_small, 26'b0} >> exp_diff;
   assign small_al   = (exp_diff > 8'd26) ? {26'b0, |man_small} :
                       {small_wide[49:24], |small_wide[23:0]};

   logic        s3_sign, s3_sub, s3_inf, s3_inf_sign, s3_zero_sign;
   exp_t        s3_exp;
   logic [26:0] s3_big, s3_small;

   always_ff @(posedge clk) begin
      s3_sign      <= a_big ? s2_sign_a : s2_sign_b;
      s3_sub       <= s2_sign_a ^ s2_sign_b;
      s3_exp       <= a_big ? s2_exp_a : s2_exp_b;
      s3_big       <= {man_big, 3'b000};
      s3_small     <= small_al;
      s3_inf       <= inf_a | inf_b;
      s3_inf_sign  <= inf_a ? s2_sign_a : s2_sign_b;
      // exact zero is negative only for -0 plus -0
      s3_zero_sign <= s2_sign_a & s2_sign_b;
   end

   // stage 3: big >= small, so the difference is already a magnitude
   logic [27:0] sum;

   assign sum = s3_sub ? ({1'b0, s3_big} - {1'b0, s3_small}) :
                         ({1'b0, s3_big} + {1'b0, s3_small});

   logic [27:0] s4_sum;
   exp_t        s4_exp;
   logic        s4_sign, s4_inf, s4_inf_sign, s4_zero_sign;

   always_ff @(posedge clk) begin
      s4_sum       <= sum;
      s4_exp       <= s3_exp;
      s4_sign      <= s3_sign;
      s4_inf       <= s3_inf;
      s4_inf_sign  <= s3_inf_sign;
      s4_zero_sign <= s3_zero_sign;
   end

   // stage 4: normalize and round to nearest even
   shift_t      lz_cnt;
   logic        lz_zero;
   logic        sum_zero;
   logic [26:0] norm;
   man_t        m_pre;
   logic        g_bit, st_bit, rnd_up;
   logic [24:0] m_rnd;
   exp_wide_t   exp_n, exp_r;
   logic [22:0] frac;

   lzc24 u_lzc (
      .man        (s4_sum[26:3]),
      .zero_count (lz_cnt),
      .all_zero   (lz_zero)
   );

   // a lone guard bit can survive a one-place alignment, so check it too
   assign sum_zero = lz_zero && !s4_sum[27] && (s4_sum[2:0] == 3'b000);
   assign norm     = s4_sum[26:0] << lz_cnt;

   always_comb begin
      if (s4_sum[27]) begin
         // carry out, one place right
         m_pre  = s4_sum[27:4];
         g_bit  = s4_sum[3];
         st_bit = |s4_sum[2:0];
         exp_n  = {2'b00, s4_exp} + 10'd1;
      end else begin
         m_pre  = norm[26:3];
         g_bit  = norm[2];
         st_bit = |norm[1:0];
         exp_n  = {2'b00, s4_exp} - {5'b00000, lz_cnt};
      end
   end

   assign rnd_up = g_bit & (st_bit | m_pre[0]);
   assign m_rnd  = {1'b0, m_pre} + {24'b0, rnd_up};
   // rounding up all ones carries into a new leading bit
   assign exp_r  = m_rnd[24] ? (exp_n + 10'd1) : exp_n;
   assign frac   = m_rnd[24] ? m_rnd[23:1] : m_rnd[22:0];

   logic        s5_sign, s5_zero, s5_inf, s5_inf_sign, s5_zero_sign;
   exp_wide_t   s5_exp;
   logic [22:0] s5_frac;

   always_ff @(posedge clk) begin
      s5_sign      <= s4_sign;
      s5_zero      <= sum_zero;
      s5_exp       <= exp_r;
      s5_frac      <= frac;
      s5_inf       <= s4_inf;
      s5_inf_sign  <= s4_inf_sign;
      s5_zero_sign <= s4_zero_sign;
   end

   // stage 5: pack with the special result rules
   always_comb begin
      overflow  = 1'b0;
      underflow = 1'b0;
      if (s5_inf) begin
         result = {s5_inf_sign, EXP_MAX, 23'b0};
      end else if (s5_zero) begin
         result = {s5_zero_sign, 31'b0};
      end else if ($signed(s5_exp) >= 255) begin
         result   = {s5_sign, EXP_MAX, 23'b0};
         overflow = 1'b1;
      end else if ($signed(s5_exp) < 1) begin
         result    = {s5_sign, 31'b0};
         underflow = 1'b1;
      end else begin
         result = {s5_sign, s5_exp[7:0], s5_frac};
      end
   end

endmodule

`default_nettype wire

/* lzc24.sv */
`default_nettype none

module lzc24
   import fp_pkg::*;
(
   input  man_t   man,
   output shift_t zero_count,
   output logic   all_zero
);

   // nibble 0 is the top nibble, man[23:20]
   logic [1:0] nib_cnt [6];
   logic [5:0] nib_zero;

   for (genvar g = 0; g < 6; g++) begin : g_nib
      logic [3:0] nib;

      assign nib         = man[23 - 4 * g -: 4];
      assign nib_zero[g] = (nib == 4'b0000);
      assign nib_cnt[g]  = nib[3] ? 2'd0 :
                           nib[2] ? 2'd1 :
                           nib[1] ? 2'd2 : 2'd3;
   end

   assign all_zero = &nib_zero;

   // the topmost non-zero nibble wins, scanning upward from the bottom
   // an all-zero mantissa gives 24
   always_comb begin
      zero_count = shift_t'(24);
      for (int i = 5; i >= 0; i--) begin
         if (!nib_zero[i]) begin
            zero_count = shift_t'(4 * i) + shift_t'(nib_cnt[i]);
         end
      end
   end

endmodule

`default_nettype wire

/* fp_pkg.sv */
`default_nettype none

package fp_pkg;

   // binary32 value and its fields
   typedef logic [31:0] fp32_t;
   typedef logic [7:0]  exp_t;
   // exponent with room for overflow and a negative underflow
   typedef logic [9:0]  exp_wide_t;
   // mantissa including the hidden bit
   typedef logic [23:0] man_t;
   typedef logic [4:0]  shift_t;

   // wishbone word address and data
   typedef logic [2:0]  wb_adr_t;
   typedef logic [31:0] wb_dat_t;

   // register map
   localparam wb_adr_t ADR_OP_A   = 3'd0;
   localparam wb_adr_t ADR_OP_B   = 3'd1;
   localparam wb_adr_t ADR_CTRL   = 3'd2;
   localparam wb_adr_t ADR_RESULT = 3'd3;
   localparam wb_adr_t ADR_STATUS = 3'd4;

   // clocks from in_valid sampled to out_valid sampled
   localparam int PIPE_LAT  = 4;

   // result queue
   localparam int RES_DEPTH = 4;
   localparam int CNT_W     = 3;
   localparam int PTR_W     = 2;

   // all-ones exponent, used for infinity
   localparam exp_t EXP_MAX = 8'hff;

endpackage

`default_nettype wire
